/* files.f */
hdl/hyper_pkg.sv
hdl/hyper_seq_if.sv
hdl/hyper_latency_cfg.sv
hdl/hyper_sequencer.sv
hdl/hyper_tx_path.sv
hdl/hyper_rx_capture.sv
hdl/hyper_ctrl_top.sv
test/hyper_ram_model.sv
test/hyper_ctrl_checker.sv
test/tb_hyper_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_hyper_ctrl -f files.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

/* test/tb_hyper_ctrl.sv */
// --------------------
// HyperRAM controller testbench
// Writes, bursts, CR0 update and CA packing checks
// --------------------
`timescale 1ns/1ps

module tb_hyper_ctrl;
  import hyper_pkg::*;

  localparam int SINGLE_COUNT = 8;
  localparam int BURST_LEN    = 5;
  localparam int TIMEOUT      = 2000;

  logic   clk = 1'b0;
  logic   reset;
  logic   rd_req;
  logic   wr_req;
  logic   mem_or_reg;
  dwcnt_t rd_num_dwords;
  dword_t addr;
  dword_t wr_d;
  dword_t rd_d;
  logic   rd_rdy;
  logic   busy;
  logic   burst_wr_rdy;
  logic   lat_2x;
  logic   dram_cs_l;
  logic   dram_ck_en;
  word_t  dram_dq_in;
  word_t  dram_dq_out;
  logic   dram_dq_oe_l;
  logic   dram_rwds_in;
  logic   dram_rwds_oe_l;
  logic   model_2x;

  int     seed = 32'hcb01d60c;
  int     errors = 0;
  int     cmp_errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     err_mark = 0;
  int     rdy_count = 0;
  int     exp_wr = 0;
  int     exp_rd = 0;
  int     cs_cyc = 0;
  logic   timed_out = 1'b0;
  ca_t    ca_seen;
  dword_t exp_arr [256];
  dword_t ref_mem [int unsigned];
  dword_t wdata [8];
  dword_t single_addr [SINGLE_COUNT];
  dword_t tmp;

  always #10 clk = ~clk;

  hyper_ctrl_top UUT (.*);

  hyper_ram_model u_ram (
    .clk          (clk),
    .reset        (reset),
    .dram_cs_l    (dram_cs_l),
    .dram_dq_out  (dram_dq_out),
    .dram_dq_in   (dram_dq_in),
    .dram_rwds_in (dram_rwds_in),
    .lat_2x_used  (model_2x)
  );

  // --------------------
  // Reference model
  function automatic int unsigned dw_index(dword_t a);
    return {3'b000, a[30:2]};
  endfunction

  // Expected read data from the reference memory
  function automatic dword_t expected_read(dword_t a);
    if (ref_mem.exists(dw_index(a))) begin
      return ref_mem[dw_index(a)];
    end
    return '0;
  endfunction

  // Command/address word as the bus rules define it
  function automatic ca_t pack_ca(logic rd, logic rg, dword_t a);
    ca_t c;
    c = '0;
    c[47] = rd;
    c[46] = rg;
    c[45] = 1'b1;
    if (rg) begin
      c[44:16] = a[31:3];
      c[2:0]   = a[2:0];
    end else begin
      c[44:16] = a[30:2];
      c[2:0]   = {a[1:0], 1'b0};
    end
    return c;
  endfunction

  function automatic dword_t rand_addr();
    dword_t r;
    r = $random(seed);
    return {1'b0, r[28:0], 2'b00};
  endfunction

  // Compare every read result as it arrives
  always @(posedge clk) begin
    if (!reset && rd_rdy) begin
      rdy_count = rdy_count + 1;
      assert (exp_rd < exp_wr)
        else begin
          $display("rd_rdy arrived with no read pending");
          cmp_errors++;
        end
      if (exp_rd < exp_wr) begin
        assert (rd_d === exp_arr[exp_rd])
          else begin
            $display("FAILED rd_d: got %h expected %h", rd_d, exp_arr[exp_rd]);
            cmp_errors++;
          end
        exp_rd = exp_rd + 1;
      end
    end
  end

  // Capture the three CA words of each transaction
  always @(posedge clk) begin
    if (!reset) begin
      // Clock enable mirrors chip select
      assert (dram_ck_en === !dram_cs_l)
        else begin
          $display("FAILED dram_ck_en: got %h expected %h", dram_ck_en, !dram_cs_l);
          errors++;
        end
    end
    if (reset || dram_cs_l) begin
      cs_cyc = 0;
    end else begin
      if (cs_cyc < 3) begin
        ca_seen[47-16*cs_cyc -: 16] = dram_dq_out;
      end
      cs_cyc = cs_cyc + 1;
    end
  end

  // --------------------
  // Reporting
  task automatic check_val(string name, logic [47:0] got, logic [47:0] exp);
    assert (got === exp)
      else begin
        $display("FAILED %s: got %h expected %h", name, got, exp);
        errors++;
      end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors + cmp_errors != err_mark) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
    err_mark = errors + cmp_errors;
  endtask

  task automatic finish_run();
    int total;
    total = errors + cmp_errors + UUT.u_checker.fail_rdy + UUT.u_checker.fail_wr_rdy
          + UUT.u_checker.fail_oe + UUT.u_checker.fail_cs;
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, total);
    if (tests_failed == 0 && total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // Later waits give up at once after the first timeout
  task automatic report_timeout(string what);
    $display("timeout: %s after %0d cycles", what, TIMEOUT);
    errors++;
    timed_out = 1'b1;
  endtask

  // --------------------
  // Bus transactions
  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk);
    while (busy && !timed_out && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (busy && !timed_out) begin
      report_timeout("busy never fell");
    end
  endtask

  // Write wdata[0..n-1], extending the burst on each burst_wr_rdy
  task automatic write_burst(dword_t a, int n);
    int loaded;
    int two_x;
    int guard;
    wait_idle();
    wr_req     <= 1'b1;
    rd_req     <= 1'b0;
    mem_or_reg <= 1'b0;
    addr       <= a;
    wr_d       <= wdata[0];
    for (int i = 0; i < n; i++) begin
      ref_mem[dw_index(a) + i] = wdata[i];
    end
    @(posedge clk);
    loaded = 1;
    if (n > 1) begin
      wr_d <= wdata[1];
    end else begin
      wr_req <= 1'b0;
    end
    two_x = 0;
    guard = 0;
    do begin
      @(posedge clk);
      guard++;
      if (lat_2x) begin
        two_x++;
      end
      // This edge took wr_d as the next dword
      if (burst_wr_rdy && wr_req) begin
        loaded++;
        if (loaded < n) begin
          wr_d <= wdata[loaded];
        end else begin
          wr_req <= 1'b0;
        end
      end
    end while (busy && !timed_out && guard < TIMEOUT);
    if (busy && !timed_out) begin
      report_timeout("write burst never ended");
    end
    check_val("lat_2x pulses", 48'(two_x), model_2x ? 48'd1 : 48'd0);
    check_val("dwords loaded", 48'(loaded), 48'(n));
  endtask

  task automatic read_burst(dword_t a, int n);
    int start_cnt;
    wait_idle();
    rd_req        <= 1'b1;
    wr_req        <= 1'b0;
    mem_or_reg    <= 1'b0;
    addr          <= a;
    rd_num_dwords <= dwcnt_t'(n);
    for (int i = 0; i < n; i++) begin
      exp_arr[exp_wr + i] = expected_read(a + dword_t'(4 * i));
    end
    exp_wr    = exp_wr + n;
    start_cnt = rdy_count;
    @(posedge clk);
    rd_req <= 1'b0;
    wait_idle();
    check_val("rd_rdy count", 48'(rdy_count - start_cnt), 48'(n));
  endtask

  task automatic reg_write(dword_t a, dword_t d);
    wait_idle();
    wr_req     <= 1'b1;
    rd_req     <= 1'b0;
    mem_or_reg <= 1'b1;
    addr       <= a;
    wr_d       <= d;
    @(posedge clk);
    wr_req     <= 1'b0;
    mem_or_reg <= 1'b0;
    wait_idle();
  endtask

  // Single writes at random addresses, then read each back
  task automatic single_round();
    for (int i = 0; i < SINGLE_COUNT; i++) begin
      single_addr[i] = rand_addr();
      wdata[0] = $random(seed);
      write_burst(single_addr[i], 1);
    end
    for (int i = 0; i < SINGLE_COUNT; i++) begin
      read_burst(single_addr[i], 1);
    end
  endtask

  // --------------------
  // Test sequence
  initial begin
    reset         = 1'b1;
    rd_req        = 1'b0;
    wr_req        = 1'b0;
    mem_or_reg    = 1'b0;
    rd_num_dwords = '0;
    addr          = '0;
    wr_d          = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    check_val("busy", 48'(busy), 48'd0);
    check_val("rd_rdy", 48'(rd_rdy), 48'd0);
    check_val("burst_wr_rdy", 48'(burst_wr_rdy), 48'd0);
    check_val("lat_2x", 48'(lat_2x), 48'd0);
    check_val("dram_cs_l", 48'(dram_cs_l), 48'd1);
    check_val("dram_dq_oe_l", 48'(dram_dq_oe_l), 48'd1);
    check_val("dram_rwds_oe_l", 48'(dram_rwds_oe_l), 48'd1);
    end_test("reset_state");

    single_round();
    end_test("single_writes");

    tmp = rand_addr();
    for (int i = 0; i < BURST_LEN; i++) begin
      wdata[i] = $random(seed);
    end
    write_burst(tmp, BURST_LEN);
    read_burst(tmp, BURST_LEN);
    end_test("burst_write_read");

    // CR0 to the 83 MHz code
    tmp = $random(seed);
    tmp[FREQ_CODE_LSB +: 4] = FREQ_83;
    reg_write(CFG0_ADDR, tmp);
    single_round();
    end_test("cr0_latency_update");

    read_burst(single_addr[0], 1);
    check_val("ca read", ca_seen, pack_ca(1'b1, 1'b0, single_addr[0]));
    reg_write(CFG0_ADDR, tmp);
    check_val("ca reg write", ca_seen, pack_ca(1'b0, 1'b1, CFG0_ADDR));
    end_test("ca_packing");

    finish_run();
  end

endmodule

/* test/hyper_ctrl_checker.sv */
// --------------------
// Protocol assertions on the controller ports
// --------------------
`timescale 1ns/1ps

module hyper_ctrl_checker (
  input logic clk,
  input logic reset,
  input logic busy,
  input logic rd_rdy,
  input logic burst_wr_rdy,
  input logic dram_cs_l,
  input logic dram_dq_oe_l
);

  // Failure counts, summed by the testbench
  int fail_rdy = 0;
  int fail_wr_rdy = 0;
  int fail_oe = 0;
  int fail_cs = 0;

  rdy_in_busy: assert property (@(posedge clk) disable iff (reset) rd_rdy |-> busy)
    else begin
      fail_rdy++;
      $error("rd_rdy high while idle");
    end

  wr_rdy_in_busy: assert property (@(posedge clk) disable iff (reset) burst_wr_rdy |-> busy)
    else begin
      fail_wr_rdy++;
      $error("burst_wr_rdy high while idle");
    end

  // DQ only driven with the chip selected
  oe_needs_cs: assert property (@(posedge clk) disable iff (reset) !dram_dq_oe_l |-> !dram_cs_l)
    else begin
      fail_oe++;
      $error("dq driven with chip deselected");
    end

  cs_idle: assert property (@(posedge clk) disable iff (reset)
    (!busy && $past(!busy)) |-> dram_cs_l)
    else begin
      fail_cs++;
      $error("chip select low while idle");
    end

endmodule

bind hyper_ctrl_top hyper_ctrl_checker u_checker (
  .clk          (clk),
  .reset        (reset),
  .busy         (busy),
  .rd_rdy       (rd_rdy),
  .burst_wr_rdy (burst_wr_rdy),
  .dram_cs_l    (dram_cs_l),
  .dram_dq_oe_l (dram_dq_oe_l)
);

/* test/hyper_ram_model.sv */
// --------------------
// Behavioral HyperRAM, one word per clock
// Decodes command/address, stores writes, streams reads
// --------------------
`timescale 1ns/1ps

module hyper_ram_model (
  input  logic              clk,
  input  logic              reset,
  input  logic              dram_cs_l,
  input  hyper_pkg::word_t  dram_dq_out,
  output hyper_pkg::word_t  dram_dq_in,
  output logic              dram_rwds_in,
  output logic              lat_2x_used
);
  import hyper_pkg::*;

  dword_t      mem [int unsigned];
  lat_cfg_t    lat = LAT_DEFAULT;
  ca_t         ca;
  word_t       hi_w;
  dword_t      rd_dw;
  dword_t      tmp;
  int          seed = 32'hcb01d60c;
  int          cyc = 0;
  int          lat_n = 0;
  int          gap = 0;
  int          k;
  int unsigned base = 0;
  int unsigned word_idx = 0;
  logic        chose;
  // Pin drivers start quiet
  word_t       dq_q = '0;
  logic        rwds_q = 1'b0;
  logic        used_q = 1'b0;

  assign dram_dq_in   = dq_q;
  assign dram_rwds_in = rwds_q;
  assign lat_2x_used  = used_q;

  always @(posedge clk) begin
    if (reset) begin
      cyc = 0;
      lat = LAT_DEFAULT;
      rwds_q <= 1'b0;
      used_q <= 1'b0;
    end else if (dram_cs_l) begin
      cyc = 0;
      rwds_q <= 1'b0;
    end else begin
      // cyc names the CS cycle that just ended
      if (cyc == 0) begin
        ca[47:32] = dram_dq_out;
        if (!dram_dq_out[15] && !dram_dq_out[14]) begin
          // Memory write, pick 1x or 2x and show it on RWDS
          tmp = $random(seed);
          chose = tmp[0];
          lat_n = chose ? int'(lat.lat_2x) : int'(lat.lat_1x);
          rwds_q <= chose;
          used_q <= chose;
        end
      end else if (cyc == 1) begin
        ca[31:16] = dram_dq_out;
      end else if (cyc == 2) begin
        ca[15:0] = dram_dq_out;
        rwds_q <= 1'b0;
        base = {3'b000, ca[44:16]};
        word_idx = 0;
        tmp = $random(seed);
        gap = 2 + int'(tmp[1:0]);
      end else if (ca[CA_RW_BIT]) begin
        // Read stream with random idle gaps
        if (gap > 0) begin
          gap = gap - 1;
          rwds_q <= 1'b0;
        end else begin
          rd_dw = mem.exists(base + word_idx / 2) ? mem[base + word_idx / 2] : '0;
          dq_q <= word_idx[0] ? rd_dw[15:0] : rd_dw[31:16];
          rwds_q <= 1'b1;
          word_idx = word_idx + 1;
          tmp = $random(seed);
          gap = (tmp[1:0] == 2'b00) ? 1 + int'(tmp[2]) : 0;
        end
      end else if (ca[CA_AS_BIT]) begin
        // Register write, only CR0 changes the latency pair
        if (cyc == 3 && {ca[44:16], ca[2:0]} == CFG0_ADDR) begin
          case (dram_dq_out[FREQ_CODE_LSB-16 +: 4])
            FREQ_166: lat = LAT_166;
            FREQ_133: lat = LAT_133;
            FREQ_100: lat = LAT_100;
            FREQ_83:  lat = LAT_83;
            default:  lat = lat;
          endcase
        end
      end else begin
        k = cyc - 3 - lat_n;
        if (k >= 0) begin
          if (k % 2 == 0) begin
            hi_w = dram_dq_out;
          end else begin
            mem[base + int'(k / 2)] = {hi_w, dram_dq_out};
          end
        end
      end
      cyc = cyc + 1;
    end
  end

endmodule

/* hdl/hyper_ctrl_top.sv */
// --------------------
// HyperRAM dword controller top
// User request port and word-per-clock pins
// --------------------
`timescale 1ns/1ps

module hyper_ctrl_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               rd_req,
  input  logic               wr_req,
  input  logic               mem_or_reg,
  input  hyper_pkg::dwcnt_t  rd_num_dwords,
  input  hyper_pkg::dword_t  addr,
  input  hyper_pkg::dword_t  wr_d,
  output hyper_pkg::dword_t  rd_d,
  output logic               rd_rdy,
  output logic               busy,
  output logic               burst_wr_rdy,
  output logic               lat_2x,
  output logic               dram_cs_l,
  output logic               dram_ck_en,
  input  hyper_pkg::word_t   dram_dq_in,
  output hyper_pkg::word_t   dram_dq_out,
  output logic               dram_dq_oe_l,
  input  logic               dram_rwds_in,
  output logic               dram_rwds_oe_l
);
  import hyper_pkg::*;

  lat_cfg_t lat_cfg;
  logic     rd_done;

  hyper_seq_if u_seq_if ();

  // --------------------
  // Latency table and sequencer
  hyper_latency_cfg u_latency_cfg (
    .clk        (clk),
    .reset      (reset),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .busy       (busy),
    .mem_or_reg (mem_or_reg),
    .addr       (addr),
    .wr_d       (wr_d),
    .lat_cfg    (lat_cfg)
  );

  hyper_sequencer u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .mem_or_reg   (mem_or_reg),
    .lat_cfg      (lat_cfg),
    .dram_rwds_in (dram_rwds_in),
    .rd_done      (rd_done),
    .busy         (busy),
    .burst_wr_rdy (burst_wr_rdy),
    .lat_2x       (lat_2x),
    .seq          (u_seq_if.seq)
  );

  // --------------------
  // Pin datapaths
  hyper_tx_path u_tx_path (
    .clk            (clk),
    .reset          (reset),
    .addr           (addr),
    .wr_d           (wr_d),
    .rd_req         (rd_req),
    .mem_or_reg     (mem_or_reg),
    .seq            (u_seq_if.tx),
    .dram_dq_out    (dram_dq_out),
    .dram_dq_oe_l   (dram_dq_oe_l),
    .dram_cs_l      (dram_cs_l),
    .dram_ck_en     (dram_ck_en),
    .dram_rwds_oe_l (dram_rwds_oe_l)
  );

  hyper_rx_capture u_rx_capture (
    .clk           (clk),
    .reset         (reset),
    .rd_req        (rd_req),
    .busy          (busy),
    .rd_num_dwords (rd_num_dwords),
    .dram_dq_in    (dram_dq_in),
    .dram_rwds_in  (dram_rwds_in),
    .seq           (u_seq_if.rx),
    .rd_d          (rd_d),
    .rd_rdy        (rd_rdy),
    .rd_done       (rd_done)
  );

endmodule

/* hdl/hyper_rx_capture.sv */
// --------------------
// HyperRAM read capture
// Pairs strobed words into dwords
// --------------------
`timescale 1ns/1ps

module hyper_rx_capture (
  input  logic               clk,
  input  logic               reset,
  input  logic               rd_req,
  input  logic               busy,
  input  hyper_pkg::dwcnt_t  rd_num_dwords,
  input  hyper_pkg::word_t   dram_dq_in,
  input  logic               dram_rwds_in,
  hyper_seq_if.rx            seq,
  output hyper_pkg::dword_t  rd_d,
  output logic               rd_rdy,
  output logic               rd_done
);
  import hyper_pkg::*;

  dwcnt_t rd_cnt;
  // Ping-pong, high once the upper word is held
  logic   pong;
  word_t  hi_word;
  logic   strobe;

  assign strobe = seq.read_armed & dram_rwds_in & (rd_cnt != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_cnt  <= '0;
      pong    <= 1'b0;
      rd_rdy  <= 1'b0;
      rd_done <= 1'b0;
    end else begin
      rd_rdy  <= 1'b0;
      rd_done <= 1'b0;
      if (rd_req && !busy) begin
        rd_cnt <= rd_num_dwords;
      end
      if (!seq.read_armed) begin
        pong <= 1'b0;
      end else if (strobe) begin
        pong <= ~pong;
        // Second word closes the dword
        if (pong) begin
          rd_rdy  <= 1'b1;
          rd_cnt  <= rd_cnt - 6'd1;
          rd_done <= (rd_cnt == 6'd1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (strobe && !pong) begin
      hi_word <= dram_dq_in;
    end
    if (strobe && pong) begin
      rd_d <= {hi_word, dram_dq_in};
    end
  end

endmodule

/* hdl/hyper_tx_path.sv */
// --------------------
// HyperRAM transmit path
// Packs command/address, shifts words out
// and registers every pin output
// --------------------
`timescale 1ns/1ps

module hyper_tx_path (
  input  logic               clk,
  input  logic               reset,
  input  hyper_pkg::dword_t  addr,
  input  hyper_pkg::dword_t  wr_d,
  input  logic               rd_req,
  input  logic               mem_or_reg,
  hyper_seq_if.tx            seq,
  output hyper_pkg::word_t   dram_dq_out,
  output logic               dram_dq_oe_l,
  output logic               dram_cs_l,
  output logic               dram_ck_en,
  output logic               dram_rwds_oe_l
);
  import hyper_pkg::*;

  ca_t    ca_next;
  ca_t    ca_reg;
  dword_t data_reg;
  word_t  word_sel;

  // Command/address packing, linear burst always
  always_comb begin
    ca_next               = '0;
    ca_next[CA_RW_BIT]    = rd_req;
    ca_next[CA_AS_BIT]    = mem_or_reg;
    ca_next[CA_BURST_BIT] = 1'b1;
    if (mem_or_reg) begin
      // Register space keeps the word select bit
      ca_next[44:16] = addr[31:3];
      ca_next[2:0]   = addr[2:0];
    end else begin
      ca_next[44:16] = addr[30:2];
      ca_next[2:0]   = {addr[1:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (seq.start) begin
      ca_reg   <= ca_next;
      data_reg <= wr_d;
    end else if (seq.load_next) begin
      // Next burst dword
      data_reg <= wr_d;
    end
  end

  // Outgoing word, highest command/address word first
  always_comb begin
    word_sel = '0;
    if (seq.ca_shift) begin
      case (seq.ca_idx)
        2'd0:    word_sel = ca_reg[47:32];
        2'd1:    word_sel = ca_reg[31:16];
        default: word_sel = ca_reg[15:0];
      endcase
    end else if (seq.data_hi) begin
      word_sel = data_reg[31:16];
    end else if (seq.data_lo) begin
      word_sel = data_reg[15:0];
    end
  end

  always_ff @(posedge clk) begin
    dram_dq_out <= word_sel;
  end

  // Pin control register stage
  always_ff @(posedge clk) begin
    if (reset) begin
      dram_cs_l      <= 1'b1;
      dram_ck_en     <= 1'b0;
      dram_dq_oe_l   <= 1'b1;
      dram_rwds_oe_l <= 1'b1;
    end else begin
      dram_cs_l      <= ~seq.cs_active;
      dram_ck_en     <= seq.cs_active;
      dram_dq_oe_l   <= ~(seq.cs_active & ~seq.read_phase);
      dram_rwds_oe_l <= ~seq.rwds_drive;
    end
  end

endmodule

/* hdl/hyper_sequencer.sv */
// --------------------
// HyperRAM transaction sequencer
// Walks command/address, then register write,
// write latency and burst, or read wait
// --------------------
`timescale 1ns/1ps

module hyper_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rd_req,
  input  logic                 wr_req,
  input  logic                 mem_or_reg,
  input  hyper_pkg::lat_cfg_t  lat_cfg,
  input  logic                 dram_rwds_in,
  input  logic                 rd_done,
  output logic                 busy,
  output logic                 burst_wr_rdy,
  output logic                 lat_2x,
  hyper_seq_if.seq             seq
);
  import hyper_pkg::*;

  // One-hot phase, bit k prepares pin cycle CSk
  logic [CA_WORDS:0] ph;
  logic              go;
  logic              is_rd;
  logic              is_reg;
  logic              cs_active;
  logic              read_phase;
  logic              read_armed;
  logic              rwds_drive;
  logic              data_hi;
  logic              data_lo;
  lat_t              wait_cnt;
  logic              start;
  logic              mem_wr;
  logic              reg_wr;

  assign start  = ~busy & (rd_req | wr_req);
  assign mem_wr = ~is_rd & ~is_reg;
  assign reg_wr = ~is_rd & is_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      go           <= 1'b0;
      ph           <= '0;
      is_rd        <= 1'b0;
      is_reg       <= 1'b0;
      busy         <= 1'b0;
      cs_active    <= 1'b0;
      read_phase   <= 1'b0;
      read_armed   <= 1'b0;
      rwds_drive   <= 1'b0;
      data_hi      <= 1'b0;
      data_lo      <= 1'b0;
      burst_wr_rdy <= 1'b0;
      lat_2x       <= 1'b0;
      wait_cnt     <= '0;
    end else begin
      go           <= start;
      ph           <= {ph[CA_WORDS-1:0], go};
      lat_2x       <= 1'b0;
      data_hi      <= 1'b0;
      // Lower half always follows the upper half of a memory write
      data_lo      <= data_hi & mem_wr;
      // Marks the cycle the upper half sits on the pins
      burst_wr_rdy <= data_hi & mem_wr;
      if (start) begin
        busy   <= 1'b1;
        is_rd  <= rd_req;
        is_reg <= mem_or_reg;
      end
      // Chip select with RWDS pulled low for CS0 only
      if (go) begin
        cs_active  <= 1'b1;
        rwds_drive <= 1'b1;
      end
      if (ph[0]) begin
        rwds_drive <= 1'b0;
      end
      // Last command/address word queued
      if (ph[CA_WORDS-1]) begin
        if (is_rd) begin
          read_phase <= 1'b1;
        end
        // Register data goes straight out on CS3
        if (reg_wr) begin
          data_hi <= 1'b1;
        end
      end
      // Pins now show CS2, device reports latency on RWDS
      if (ph[RWDS_SAMPLE_CYCLE+1]) begin
        if (is_rd) begin
          read_armed <= 1'b1;
        end
        if (reg_wr) begin
          busy      <= 1'b0;
          cs_active <= 1'b0;
        end
      end
      // Latency countdown, first data half lands on CS(3+L)
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 6'd1;
        if (wait_cnt == 6'd1) begin
          data_hi    <= 1'b1;
          rwds_drive <= 1'b1;
        end
      end
      if (ph[RWDS_SAMPLE_CYCLE+1] && mem_wr) begin
        lat_2x   <= dram_rwds_in;
        wait_cnt <= dram_rwds_in ? lat_cfg.lat_2x - 6'd1 : lat_cfg.lat_1x - 6'd1;
      end
      // Burst continues only with a new write request here
      if (data_lo) begin
        if (wr_req) begin
          data_hi <= 1'b1;
        end else begin
          busy       <= 1'b0;
          cs_active  <= 1'b0;
          rwds_drive <= 1'b0;
        end
      end
      // Last read dword delivered
      if (rd_done) begin
        busy       <= 1'b0;
        cs_active  <= 1'b0;
        read_phase <= 1'b0;
        read_armed <= 1'b0;
      end
    end
  end

  // Command bundle for the datapaths
  assign seq.start      = start;
  assign seq.ca_shift   = |ph[CA_WORDS-1:0];
  assign seq.ca_idx     = ph[1] ? 2'd1 : (ph[2] ? 2'd2 : 2'd0);
  assign seq.data_hi    = data_hi;
  assign seq.data_lo    = data_lo;
  assign seq.load_next  = data_lo & wr_req;
  assign seq.cs_active  = cs_active;
  assign seq.read_phase = read_phase;
  assign seq.rwds_drive = rwds_drive;
  assign seq.read_armed = read_armed;

endmodule

/* hdl/hyper_latency_cfg.sv */
// --------------------
// HyperRAM latency table
// Tracks CR0 writes so the write latency
// matches what the device was told
// --------------------
`timescale 1ns/1ps

module hyper_latency_cfg (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr_req,
  input  logic                 rd_req,
  input  logic                 busy,
  input  logic                 mem_or_reg,
  input  hyper_pkg::dword_t    addr,
  input  hyper_pkg::dword_t    wr_d,
  output hyper_pkg::lat_cfg_t  lat_cfg
);
  import hyper_pkg::*;

  logic cfg_wr;

  // Accepted register write to CR0, a read request wins over a write
  assign cfg_wr = wr_req & ~rd_req & ~busy & mem_or_reg & (addr == CFG0_ADDR);

  always_ff @(posedge clk) begin
    if (reset) begin
      // Device power-on setting
      lat_cfg <= LAT_DEFAULT;
    end else if (cfg_wr) begin
      case (wr_d[FREQ_CODE_LSB +: 4])
        FREQ_166: lat_cfg <= LAT_166;
        FREQ_133: lat_cfg <= LAT_133;
        FREQ_100: lat_cfg <= LAT_100;
        FREQ_83:  lat_cfg <= LAT_83;
        // Unknown code keeps the old pair
        default:  lat_cfg <= lat_cfg;
      endcase
    end
  end

endmodule

/* hdl/hyper_seq_if.sv */
// --------------------
// Sequencer command bundle
// Steers the transmit and receive paths
// --------------------
`timescale 1ns/1ps

interface hyper_seq_if;

  logic       start;
  logic [1:0] ca_idx;
  logic       ca_shift;
  logic       data_hi;
  logic       data_lo;
  logic       load_next;
  logic       cs_active;
  logic       read_phase;
  logic       rwds_drive;
  logic       read_armed;

  modport seq (
    output start, ca_idx, ca_shift, data_hi, data_lo, load_next,
    output cs_active, read_phase, rwds_drive, read_armed
  );

  modport tx (
    input start, ca_idx, ca_shift, data_hi, data_lo, load_next,
    input cs_active, read_phase, rwds_drive
  );

  modport rx (input read_armed);

endinterface

/* hdl/hyper_pkg.sv */
// --------------------
// HyperRAM controller shared types
// Command/address layout and latency table
// --------------------
package hyper_pkg;

  // Data widths
  typedef logic [31:0] dword_t;
  typedef logic [15:0] word_t;
  typedef logic [47:0] ca_t;
  typedef logic [5:0]  lat_t;
  typedef logic [5:0]  dwcnt_t;

  // Latency pair in clocks
  typedef struct packed {
    lat_t lat_2x;
    lat_t lat_1x;
  } lat_cfg_t;

  // Command/address bit positions
  localparam int CA_RW_BIT    = 47;
  localparam int CA_AS_BIT    = 46;
  localparam int CA_BURST_BIT = 45;

  // CR0 lives here in register space
  localparam dword_t CFG0_ADDR     = 32'h0000_0800;
  localparam int     FREQ_CODE_LSB = 20;

  // Three words of command/address, RWDS checked on the last one
  localparam int CA_WORDS          = 3;
  localparam int RWDS_SAMPLE_CYCLE = 2;

  // CR0 frequency codes
  localparam logic [3:0] FREQ_166 = 4'h1;
  localparam logic [3:0] FREQ_133 = 4'h0;
  localparam logic [3:0] FREQ_100 = 4'hF;
  localparam logic [3:0] FREQ_83  = 4'hE;

  // Matching 2x/1x latency pairs
  localparam lat_cfg_t LAT_166     = '{lat_2x: 6'd10, lat_1x: 6'd7};
  localparam lat_cfg_t LAT_133     = '{lat_2x: 6'd8, lat_1x: 6'd6};
  localparam lat_cfg_t LAT_100     = '{lat_2x: 6'd6, lat_1x: 6'd5};
  localparam lat_cfg_t LAT_83      = '{lat_2x: 6'd4, lat_1x: 6'd4};
  localparam lat_cfg_t LAT_DEFAULT = LAT_166;

endpackage
